// File: source/board_settings.svh
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

// Player input widths
`define BOARD_JOYW              10
`define BOARD_BOARDJOYW         16
`define BOARD_FIRE_BIT          4

// OSD status word
`define BOARD_STATUSW           64

// Reset hold counts, in snd_sample cycles
`define BOARD_RST_CYCLES        16
`define BOARD_GAME_RST_CYCLES   8

// Frame based timing, counted in vs rising edges
`define BOARD_AUTOFIRE_FRAMES   2
`define BOARD_BLINK_FRAMES      16

// Status word bit positions
`define BOARD_ST_FLIP           1
`define BOARD_ST_TEST           2
`define BOARD_ST_PAUSE          3
// Two bit field
`define BOARD_ST_FX_LO          4
`define BOARD_ST_NOFM           6
`define BOARD_ST_NOPSG          7
// Two bit field
`define BOARD_ST_ROT_LO         8
`define BOARD_ST_AUTOFIRE       18

`endif

// File: source/board_pkg.sv
`default_nettype none

package board_pkg;

    // Reset sequencer states
    typedef enum logic [1:0] {
        RST_HOLD,
        RST_GAME,
        RST_RUN
    } rst_state_t;

    // Activity LED source, highest priority first
    typedef enum logic [1:0] {
        LED_DOWNLOAD,
        LED_OSD,
        LED_GAME
    } led_mode_t;

endpackage

`default_nettype wire

// File: source/board_ctrl_if.sv
`default_nettype none

// Control levels shared by input merging, option decoding and reset
interface board_ctrl_if;

    // Pause toggle from the keyboard
    logic game_pause;
    // Test key, registered
    logic test_key;
    // Keyboard reset request, restarts the game only
    logic soft_rst;
    // Autofire option from the OSD
    logic autofire_en;

    modport inputs_mp (
        output game_pause,
        output test_key,
        output soft_rst,
        input  autofire_en
    );

    modport dip_mp (
        input  game_pause,
        input  test_key,
        output autofire_en
    );

    modport reset_mp (
        input  soft_rst
    );

endinterface

`default_nettype wire

// File: source/reset_seq.sv
`default_nettype none

`include "board_settings.svh"

module reset_seq (
    input  logic              snd_sample,
    input  logic              reset,
    input  logic              pll_locked,
    input  logic              rst_req,
    input  logic              downloading,
    board_ctrl_if.reset_mp    ctrl,
    output logic              rst,
    output logic              rst_n,
    output logic              game_rst,
    output logic              game_rst_n
);
    import board_pkg::*;

    localparam int CNT_MAX = (`BOARD_RST_CYCLES > `BOARD_GAME_RST_CYCLES) ?
                             `BOARD_RST_CYCLES : `BOARD_GAME_RST_CYCLES;
    localparam int CNTW = $clog2(CNT_MAX + 1);

    localparam logic [CNTW-1:0] SYS_LOAD   = CNTW'(`BOARD_RST_CYCLES);
    localparam logic [CNTW-1:0] GAME_LOAD  = CNTW'(`BOARD_GAME_RST_CYCLES);
    // One cycle is spent leaving RST_HOLD
    localparam logic [CNTW-1:0] GAME_ENTRY = CNTW'(`BOARD_GAME_RST_CYCLES - 1);

    rst_state_t      state;
    logic [CNTW-1:0] cnt;
    logic            sys_cause;
    logic            game_cause;

    assign sys_cause  = reset | ~pll_locked | rst_req;
    assign game_cause = downloading | ctrl.soft_rst;

    always_ff @(posedge snd_sample) begin
        if (sys_cause) begin
            state <= RST_HOLD;
            cnt   <= SYS_LOAD;
        end else begin
            case (state)
                RST_HOLD: begin
                    if (cnt == '0) begin
                        state <= RST_GAME;
                        cnt   <= game_cause ? GAME_LOAD : GAME_ENTRY;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                RST_GAME: begin
                    // Count restarts while any game cause remains
                    if (game_cause) begin
                        cnt <= GAME_LOAD;
                    end else if (cnt == '0) begin
                        state <= RST_RUN;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                RST_RUN: begin
                    if (game_cause) begin
                        state <= RST_GAME;
                        cnt   <= GAME_LOAD;
                    end
                end
                default: begin
                    state <= RST_HOLD;
                    cnt   <= SYS_LOAD;
                end
            endcase
        end
    end

    // Game reset covers the system hold too
    assign rst        = (state == RST_HOLD);
    assign game_rst   = (state != RST_RUN);
    assign rst_n      = ~rst;
    assign game_rst_n = ~game_rst;

endmodule

`default_nettype wire

// File: source/input_merge.sv
`default_nettype none

`include "board_settings.svh"

module input_merge (
    input  logic                        snd_sample,
    input  logic                        game_rst,
    input  logic                        vs,
    input  logic                        downloading,
    input  logic [`BOARD_BOARDJOYW-1:0] board_joystick1,
    input  logic [`BOARD_BOARDJOYW-1:0] board_joystick2,
    input  logic [`BOARD_JOYW-1:0]      key_joy1,
    input  logic [`BOARD_JOYW-1:0]      key_joy2,
    input  logic [1:0]                  board_coin,
    input  logic [1:0]                  board_start,
    input  logic [1:0]                  key_coin,
    input  logic [1:0]                  key_start,
    input  logic                        key_service,
    input  logic                        key_tilt,
    input  logic                        key_pause,
    input  logic                        key_test,
    input  logic                        key_reset,
    board_ctrl_if.inputs_mp             ctrl,
    output logic [`BOARD_JOYW-1:0]      game_joystick1,
    output logic [`BOARD_JOYW-1:0]      game_joystick2,
    output logic [1:0]                  game_coin,
    output logic [1:0]                  game_start,
    output logic                        game_service,
    output logic                        game_tilt
);
    localparam int AFW = $clog2(`BOARD_AUTOFIRE_FRAMES + 1);
    localparam logic [AFW-1:0] AF_LAST = AFW'(`BOARD_AUTOFIRE_FRAMES - 1);

    logic [`BOARD_JOYW-1:0] joy_act [2];
    logic [`BOARD_JOYW-1:0] joy_out [2];
    logic [1:0]             fire_held;
    logic [1:0]             af_phase;
    logic [AFW-1:0]         af_cnt [2];
    logic                   vs_l;
    logic                   vs_rise;
    logic                   pause_l;
    logic                   pause_flag;
    logic                   lock;

    // Active high merge of the lower board bits and the keys
    assign joy_act[0] = board_joystick1[`BOARD_JOYW-1:0] | key_joy1;
    assign joy_act[1] = board_joystick2[`BOARD_JOYW-1:0] | key_joy2;

    assign fire_held[0] = joy_act[0][`BOARD_FIRE_BIT];
    assign fire_held[1] = joy_act[1][`BOARD_FIRE_BIT];

    assign vs_rise = vs & ~vs_l;
    assign lock    = game_rst | downloading;

    // Released phase of autofire masks button 0
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            joy_out[p] = joy_act[p];
            joy_out[p][`BOARD_FIRE_BIT] = fire_held[p] & ~(ctrl.autofire_en & af_phase[p]);
        end
    end

    // Autofire phase per player starts pressed on each new hold
    always_ff @(posedge snd_sample) begin
        vs_l <= vs;
        if (game_rst) begin
            af_phase <= '0;
            af_cnt   <= '{default: '0};
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (!ctrl.autofire_en || !fire_held[p]) begin
                    af_phase[p] <= 1'b0;
                    af_cnt[p]   <= '0;
                end else if (vs_rise) begin
                    if (af_cnt[p] == AF_LAST) begin
                        af_cnt[p]   <= '0;
                        af_phase[p] <= ~af_phase[p];
                    end else begin
                        af_cnt[p] <= af_cnt[p] + 1'b1;
                    end
                end
            end
        end
    end

    // Game side is active low
    always_ff @(posedge snd_sample) begin
        if (lock) begin
            game_joystick1 <= '1;
            game_joystick2 <= '1;
            game_coin      <= '1;
            game_start     <= '1;
            game_service   <= 1'b1;
            game_tilt      <= 1'b1;
        end else begin
            game_joystick1 <= ~joy_out[0];
            game_joystick2 <= ~joy_out[1];
            game_coin      <= ~(board_coin | key_coin);
            game_start     <= ~(board_start | key_start);
            game_service   <= ~key_service;
            game_tilt      <= ~key_tilt;
        end
    end

    // Pause key toggles on each press
    always_ff @(posedge snd_sample) begin
        pause_l <= key_pause;
        if (game_rst) begin
            pause_flag <= 1'b0;
        end else if (key_pause && !pause_l) begin
            pause_flag <= ~pause_flag;
        end
    end

    // Registered keyboard reset and test key
    always_ff @(posedge snd_sample) begin
        ctrl.soft_rst <= key_reset;
        ctrl.test_key <= key_test & ~downloading;
    end

    assign ctrl.game_pause = pause_flag;

endmodule

`default_nettype wire

// File: source/dip_decode.sv
`default_nettype none

`include "board_settings.svh"

module dip_decode (
    input  logic                      snd_sample,
    input  logic                      reset,
    input  logic [`BOARD_STATUSW-1:0] status,
    input  logic                      osd_shown,
    board_ctrl_if.dip_mp              ctrl,
    output logic                      dip_flip,
    output logic                      dip_test,
    output logic                      dip_pause,
    output logic                      enable_fm,
    output logic                      enable_psg,
    output logic [1:0]                dip_fxlevel,
    output logic [1:0]                rotate
);

    always_ff @(posedge snd_sample) begin
        if (reset) begin
            dip_flip         <= 1'b0;
            dip_test         <= 1'b0;
            dip_pause        <= 1'b0;
            enable_fm        <= 1'b0;
            enable_psg       <= 1'b0;
            dip_fxlevel      <= 2'b00;
            rotate           <= 2'b00;
            ctrl.autofire_en <= 1'b0;
        end else begin
            dip_flip    <= status[`BOARD_ST_FLIP];
            // Test mode from the OSD or the keyboard
            dip_test    <= status[`BOARD_ST_TEST] | ctrl.test_key;
            // Game halts while the OSD is open
            dip_pause   <= status[`BOARD_ST_PAUSE] | ctrl.game_pause | osd_shown;
            dip_fxlevel <= status[`BOARD_ST_FX_LO +: 2];
            rotate      <= status[`BOARD_ST_ROT_LO +: 2];
            // Status bits are disables, outputs are enables
            enable_fm   <= ~status[`BOARD_ST_NOFM];
            enable_psg  <= ~status[`BOARD_ST_NOPSG];
            ctrl.autofire_en <= status[`BOARD_ST_AUTOFIRE];
        end
    end

endmodule

`default_nettype wire

// File: source/led_ctrl.sv
`default_nettype none

`include "board_settings.svh"

module led_ctrl (
    input  logic       snd_sample,
    input  logic       rst,
    input  logic       vs,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);
    import board_pkg::*;

    localparam int BW = $clog2(`BOARD_BLINK_FRAMES + 1);
    localparam logic [BW-1:0] BLINK_LAST = BW'(`BOARD_BLINK_FRAMES - 1);

    led_mode_t     mode;
    logic          vs_l;
    logic [BW-1:0] blink_cnt;
    logic          blink;

    always_comb begin
        if (downloading) begin
            mode = LED_DOWNLOAD;
        end else if (osd_shown) begin
            mode = LED_OSD;
        end else begin
            mode = LED_GAME;
        end
    end

    // Blink keeps running outside OSD mode
    always_ff @(posedge snd_sample) begin
        if (rst) begin
            vs_l      <= 1'b0;
            blink_cnt <= '0;
            blink     <= 1'b0;
            led       <= 1'b0;
        end else begin
            vs_l <= vs;
            if (vs && !vs_l) begin
                if (blink_cnt == BLINK_LAST) begin
                    blink_cnt <= '0;
                    blink     <= ~blink;
                end else begin
                    blink_cnt <= blink_cnt + 1'b1;
                end
            end
            case (mode)
                LED_DOWNLOAD: led <= 1'b1;
                LED_OSD:      led <= blink;
                default:      led <= game_led[0];
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/board_ctrl.sv
`default_nettype none

`include "board_settings.svh"

module board_ctrl (
    input  logic                        snd_sample,
    input  logic                        reset,
    input  logic                        pll_locked,
    input  logic                        rst_req,
    input  logic                        downloading,
    input  logic                        vs,
    input  logic                        osd_shown,
    input  logic [1:0]                  game_led,
    input  logic [`BOARD_STATUSW-1:0]   status,
    input  logic [`BOARD_BOARDJOYW-1:0] board_joystick1,
    input  logic [`BOARD_BOARDJOYW-1:0] board_joystick2,
    input  logic [`BOARD_JOYW-1:0]      key_joy1,
    input  logic [`BOARD_JOYW-1:0]      key_joy2,
    input  logic [1:0]                  board_coin,
    input  logic [1:0]                  board_start,
    input  logic [1:0]                  key_coin,
    input  logic [1:0]                  key_start,
    input  logic                        key_service,
    input  logic                        key_tilt,
    input  logic                        key_pause,
    input  logic                        key_test,
    input  logic                        key_reset,
    output logic [`BOARD_JOYW-1:0]      game_joystick1,
    output logic [`BOARD_JOYW-1:0]      game_joystick2,
    output logic [1:0]                  game_coin,
    output logic [1:0]                  game_start,
    output logic                        game_service,
    output logic                        game_tilt,
    output logic                        dip_flip,
    output logic                        dip_test,
    output logic                        dip_pause,
    output logic                        enable_fm,
    output logic                        enable_psg,
    output logic [1:0]                  dip_fxlevel,
    output logic [1:0]                  rotate,
    output logic                        led,
    output logic                        rst,
    output logic                        rst_n,
    output logic                        game_rst,
    output logic                        game_rst_n
);

    board_ctrl_if ctrl_bus ();

    reset_seq u_reset (
        .snd_sample (snd_sample),
        .reset      (reset),
        .pll_locked (pll_locked),
        .rst_req    (rst_req),
        .downloading(downloading),
        .ctrl       (ctrl_bus.reset_mp),
        .rst        (rst),
        .rst_n      (rst_n),
        .game_rst   (game_rst),
        .game_rst_n (game_rst_n)
    );

    input_merge u_inputs (
        .snd_sample     (snd_sample),
        .game_rst       (game_rst),
        .vs             (vs),
        .downloading    (downloading),
        .board_joystick1(board_joystick1),
        .board_joystick2(board_joystick2),
        .key_joy1       (key_joy1),
        .key_joy2       (key_joy2),
        .board_coin     (board_coin),
        .board_start    (board_start),
        .key_coin       (key_coin),
        .key_start      (key_start),
        .key_service    (key_service),
        .key_tilt       (key_tilt),
        .key_pause      (key_pause),
        .key_test       (key_test),
        .key_reset      (key_reset),
        .ctrl           (ctrl_bus.inputs_mp),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_coin      (game_coin),
        .game_start     (game_start),
        .game_service   (game_service),
        .game_tilt      (game_tilt)
    );

    // Options use the board reset, not the game reset
    dip_decode u_dip (
        .snd_sample (snd_sample),
        .reset      (reset),
        .status     (status),
        .osd_shown  (osd_shown),
        .ctrl       (ctrl_bus.dip_mp),
        .dip_flip   (dip_flip),
        .dip_test   (dip_test),
        .dip_pause  (dip_pause),
        .enable_fm  (enable_fm),
        .enable_psg (enable_psg),
        .dip_fxlevel(dip_fxlevel),
        .rotate     (rotate)
    );

    led_ctrl u_led (
        .snd_sample (snd_sample),
        .rst        (rst),
        .vs         (vs),
        .downloading(downloading),
        .osd_shown  (osd_shown),
        .game_led   (game_led),
        .led        (led)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`default_nettype none

// Free running sample clock for the testbench
module tb_clock (
    output logic snd_sample
);
    localparam int HALF_PERIOD = 50;

    initial begin
        snd_sample = 1'b0;
        forever begin
            #HALF_PERIOD snd_sample = ~snd_sample;
        end
    end

endmodule

`default_nettype wire

// File: sim/board_ctrl_tb.sv
`default_nettype none

`include "board_settings.svh"

module board_ctrl_tb;

    localparam int WAIT_LIMIT = 200;

    logic                        snd_sample;
    logic                        reset;
    logic                        pll_locked;
    logic                        rst_req;
    logic                        downloading;
    logic                        vs;
    logic                        osd_shown;
    logic [1:0]                  game_led;
    logic [`BOARD_STATUSW-1:0]   status;
    logic [`BOARD_BOARDJOYW-1:0] board_joystick1;
    logic [`BOARD_BOARDJOYW-1:0] board_joystick2;
    logic [`BOARD_JOYW-1:0]      key_joy1;
    logic [`BOARD_JOYW-1:0]      key_joy2;
    logic [1:0]                  board_coin;
    logic [1:0]                  board_start;
    logic [1:0]                  key_coin;
    logic [1:0]                  key_start;
    logic                        key_service;
    logic                        key_tilt;
    logic                        key_pause;
    logic                        key_test;
    logic                        key_reset;
    logic [`BOARD_JOYW-1:0]      game_joystick1;
    logic [`BOARD_JOYW-1:0]      game_joystick2;
    logic [1:0]                  game_coin;
    logic [1:0]                  game_start;
    logic                        game_service;
    logic                        game_tilt;
    logic                        dip_flip;
    logic                        dip_test;
    logic                        dip_pause;
    logic                        enable_fm;
    logic                        enable_psg;
    logic [1:0]                  dip_fxlevel;
    logic [1:0]                  rotate;
    logic                        led;
    logic                        rst;
    logic                        rst_n;
    logic                        game_rst;
    logic                        game_rst_n;
    // Count of vs pulses since reset
    int                          vs_pulses = 0;

    tb_clock clk_gen (.snd_sample(snd_sample));

    board_ctrl UUT (.*);

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        assert (actual === expected) else begin
            stop_with_failure($sformatf("mismatch %s expected %0h actual %0h",
                                        name, expected, actual));
        end
    endtask

    task automatic wait_game_rst(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (game_rst !== level) begin
            @(negedge snd_sample);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_failure($sformatf("timeout waiting for %s", what));
            end
        end
    endtask

    // Number of falling edges that still see game_rst high
    task automatic count_game_rst_high(output int count);
        count = 0;
        while (game_rst === 1'b1 && count < WAIT_LIMIT) begin
            count++;
            @(negedge snd_sample);
        end
    endtask

    // Ends one cycle after vs falls so registered outputs show the pulse
    task automatic pulse_vs();
        @(negedge snd_sample);
        vs = 1'b1;
        @(negedge snd_sample);
        vs = 1'b0;
        vs_pulses++;
        @(negedge snd_sample);
    endtask

    assert property (@(posedge snd_sample) disable iff (reset) rst_n == !rst)
        else stop_with_failure("rst_n is not the inverse of rst");
    assert property (@(posedge snd_sample) disable iff (reset) game_rst_n == !game_rst)
        else stop_with_failure("game_rst_n is not the inverse of game_rst");
    assert property (@(posedge snd_sample) disable iff (reset) rst |-> game_rst)
        else stop_with_failure("game_rst is low while rst is high");

    initial begin
        logic [`BOARD_JOYW-1:0]    exp_joy1;
        logic [`BOARD_JOYW-1:0]    exp_joy2;
        logic [1:0]                exp_coin;
        logic [1:0]                exp_start;
        logic [`BOARD_STATUSW-1:0] st;
        logic                      pause_exp;
        logic                      bit_exp;
        int                        count;

        void'($urandom(32'h3d63));
        reset = 1'b1;
        pll_locked = 1'b0;
        rst_req = 1'b0;
        downloading = 1'b0;
        vs = 1'b0;
        osd_shown = 1'b0;
        game_led = '0;
        status = '0;
        {board_joystick1, board_joystick2, key_joy1, key_joy2} = '0;
        {board_coin, board_start, key_coin, key_start} = '0;
        {key_service, key_tilt, key_pause, key_test, key_reset} = '0;

        repeat (3) @(negedge snd_sample);
        reset = 1'b0;
        @(negedge snd_sample);
        check_val("idle joystick1", {`BOARD_JOYW{1'b1}}, game_joystick1);
        check_val("idle dip_pause", 1'b0, dip_pause);
        check_val("idle dip_test", 1'b0, dip_test);
        check_val("idle led", 1'b0, led);

        // Reset release once the PLL locks
        pll_locked = 1'b1;
        count = 0;
        @(negedge snd_sample);
        while (rst === 1'b1 && count < WAIT_LIMIT) begin
            count++;
            @(negedge snd_sample);
        end
        check_val("rst hold", `BOARD_RST_CYCLES, count);
        count_game_rst_high(count);
        check_val("game_rst hold", `BOARD_GAME_RST_CYCLES, count);

        downloading = 1'b1;
        repeat (3) @(negedge snd_sample);
        check_val("download game_rst", 1'b1, game_rst);
        check_val("download rst", 1'b0, rst);
        downloading = 1'b0;
        @(negedge snd_sample);
        count_game_rst_high(count);
        check_val("download release", `BOARD_GAME_RST_CYCLES, count);

        key_reset = 1'b1;
        wait_game_rst(1'b1, "game reset from key_reset");
        check_val("soft reset rst", 1'b0, rst);
        key_reset = 1'b0;
        wait_game_rst(1'b0, "game reset release after key_reset");

        // Merged inputs are active low on the game side
        repeat (20) begin
            board_joystick1 = 16'($urandom());
            board_joystick2 = 16'($urandom());
            key_joy1 = `BOARD_JOYW'($urandom());
            key_joy2 = `BOARD_JOYW'($urandom());
            {board_coin, board_start, key_coin, key_start} = 8'($urandom());
            {key_service, key_tilt} = 2'($urandom());
            @(negedge snd_sample);
            exp_joy1 = ~(board_joystick1[`BOARD_JOYW-1:0] | key_joy1);
            exp_joy2 = ~(board_joystick2[`BOARD_JOYW-1:0] | key_joy2);
            exp_coin = ~(board_coin | key_coin);
            exp_start = ~(board_start | key_start);
            check_val("merge joystick1", exp_joy1, game_joystick1);
            check_val("merge joystick2", exp_joy2, game_joystick2);
            check_val("merge coin", exp_coin, game_coin);
            check_val("merge start", exp_start, game_start);
            bit_exp = ~key_service;
            check_val("merge service", bit_exp, game_service);
            bit_exp = ~key_tilt;
            check_val("merge tilt", bit_exp, game_tilt);
        end
        downloading = 1'b1;
        @(negedge snd_sample);
        check_val("lock joystick1", {`BOARD_JOYW{1'b1}}, game_joystick1);
        check_val("lock joystick2", {`BOARD_JOYW{1'b1}}, game_joystick2);
        check_val("lock coin", 2'b11, game_coin);
        check_val("lock start", 2'b11, game_start);
        check_val("lock service", 1'b1, game_service);
        check_val("lock tilt", 1'b1, game_tilt);
        downloading = 1'b0;
        {board_joystick1, board_joystick2, key_joy1, key_joy2} = '0;
        {board_coin, board_start, key_coin, key_start, key_service, key_tilt} = '0;
        wait_game_rst(1'b0, "game reset release after merge test");

        // Autofire on button 0 of player 1
        status[`BOARD_ST_AUTOFIRE] = 1'b1;
        key_joy1[`BOARD_FIRE_BIT] = 1'b1;
        repeat (2) @(negedge snd_sample);
        check_val("autofire start", 1'b0, game_joystick1[`BOARD_FIRE_BIT]);
        for (int i = 1; i <= 8; i++) begin
            pulse_vs();
            bit_exp = 1'((i / `BOARD_AUTOFIRE_FRAMES) % 2);
            check_val("autofire toggle", bit_exp, game_joystick1[`BOARD_FIRE_BIT]);
        end
        status[`BOARD_ST_AUTOFIRE] = 1'b0;
        repeat (2) @(negedge snd_sample);
        repeat (4) begin
            pulse_vs();
            check_val("autofire off", 1'b0, game_joystick1[`BOARD_FIRE_BIT]);
        end
        key_joy1 = '0;

        // Option decoding
        repeat (20) begin
            st = {$urandom(), $urandom()};
            status = st;
            @(negedge snd_sample);
            check_val("flip", st[`BOARD_ST_FLIP], dip_flip);
            check_val("fxlevel", st[`BOARD_ST_FX_LO +: 2], dip_fxlevel);
            check_val("rotate", st[`BOARD_ST_ROT_LO +: 2], rotate);
            bit_exp = ~st[`BOARD_ST_NOFM];
            check_val("enable_fm", bit_exp, enable_fm);
            bit_exp = ~st[`BOARD_ST_NOPSG];
            check_val("enable_psg", bit_exp, enable_psg);
            check_val("status test", st[`BOARD_ST_TEST], dip_test);
            check_val("status pause", st[`BOARD_ST_PAUSE], dip_pause);
        end
        status = '0;
        key_test = 1'b1;
        repeat (2) @(negedge snd_sample);
        check_val("key test", 1'b1, dip_test);
        key_test = 1'b0;
        repeat (2) @(negedge snd_sample);
        check_val("key test release", 1'b0, dip_test);

        pause_exp = 1'b0;
        repeat (2) begin
            key_pause = 1'b1;
            pause_exp = ~pause_exp;
            repeat (2) @(negedge snd_sample);
            check_val("pause toggle", pause_exp, dip_pause);
            // Holding the key must not toggle again
            repeat (2) @(negedge snd_sample);
            check_val("pause held", pause_exp, dip_pause);
            key_pause = 1'b0;
            repeat (2) @(negedge snd_sample);
            check_val("pause release", pause_exp, dip_pause);
        end
        osd_shown = 1'b1;
        @(negedge snd_sample);
        check_val("osd pause", 1'b1, dip_pause);
        osd_shown = 1'b0;
        @(negedge snd_sample);
        check_val("osd pause release", 1'b0, dip_pause);

        // Activity LED
        downloading = 1'b1;
        @(negedge snd_sample);
        repeat (4) begin
            pulse_vs();
            check_val("download led", 1'b1, led);
        end
        downloading = 1'b0;
        wait_game_rst(1'b0, "game reset release after LED download");
        repeat (8) begin
            game_led = 2'($urandom());
            @(negedge snd_sample);
            check_val("game led", game_led[0], led);
        end
        osd_shown = 1'b1;
        @(negedge snd_sample);
        bit_exp = 1'((vs_pulses / `BOARD_BLINK_FRAMES) % 2);
        check_val("osd led entry", bit_exp, led);
        repeat (40) begin
            pulse_vs();
            bit_exp = 1'((vs_pulses / `BOARD_BLINK_FRAMES) % 2);
            check_val("osd blink", bit_exp, led);
        end
        osd_shown = 1'b0;

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: board_ctrl.f
+incdir+source
source/board_pkg.sv
source/board_ctrl_if.sv
source/reset_seq.sv
source/input_merge.sv
source/dip_decode.sv
source/led_ctrl.sv
source/board_ctrl.sv
sim/tb_clock.sv
sim/board_ctrl_tb.sv
